//--- hw/u1e_config.svh
// build constants for the u1e control plane
// bus widths, misc register map, settings indices and timer rate
`ifndef U1E_CONFIG_SVH
`define U1E_CONFIG_SVH

// register bus
`define U1E_DW            16
`define U1E_AW            11
`define U1E_SW            2
`define U1E_DEC_W         4       // top address bits pick the slave
`define U1E_SLV_MISC      4'd0
`define U1E_SLV_SETTINGS  4'd5

// misc slave offsets in bytes
`define REG_LEDS          7'd0
`define REG_SWITCHES      7'd2
`define REG_CGEN_CTRL     7'd4
`define REG_CGEN_ST       7'd6
`define REG_TEST          7'd8
`define REG_RX_FRAMELEN   7'd10
`define REG_TX_FRAMELEN   7'd12
`define REG_XFER_RATE     7'd14
`define REG_COMPAT        7'd16

`define U1E_WHOAMI        8'd0
`define U1E_COMPAT_NUM    8'd2
`define U1E_READ_DEFAULT  16'hBEEF

// settings bus
`define U1E_SET_AW        8
`define SR_CLEAR_FIFO     8'd6
`define SR_TIME64         8'd28   // secs, ticks, mode
`define U1E_TICKS_PER_SEC 32'd100 // tiny second for simulation

`endif

//--- hw/u1e_bus_pkg.sv
// register bus types
// shared by the top level, the decoder and the bus slaves
`include "u1e_config.svh"

package u1e_bus_pkg;

   // one bus word
   typedef logic [`U1E_DW-1:0]    wb_data_t;

   // byte address, top bits select the slave
   typedef logic [`U1E_AW-1:0]    wb_addr_t;

   typedef logic [`U1E_SW-1:0]    wb_sel_t;     // byte lanes

   // decoded slave number
   typedef logic [`U1E_DEC_W-1:0] slave_idx_t;

endpackage

//--- hw/u1e_settings_pkg.sv
// settings bus and VITA time types
`include "u1e_config.svh"

package u1e_settings_pkg;

   typedef logic [`U1E_SET_AW-1:0]  set_addr_t;
   typedef logic [1:0][`U1E_DW-1:0] set_data_t;   // {high, low} words

   // seconds in words 3..2, ticks in words 1..0
   typedef logic [3:0][`U1E_DW-1:0] vita_time_t;

   typedef logic [31:0] vita_secs_t;
   typedef logic [31:0] vita_ticks_t;

endpackage

//--- hw/wb_slave_decode.sv
// single-master register bus decode
// slave strobes, ack and read data return, default slave for holes
`timescale 1ns/1ps
`include "u1e_config.svh"

module wb_slave_decode
   import u1e_bus_pkg::*;
(
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  logic     cyc_i,
   input  logic     stb_i,
   input  wb_addr_t adr_i,
   output logic     misc_stb_o,
   output logic     set_stb_o,
   input  logic     misc_ack_i,
   input  wb_data_t misc_dat_i,
   input  logic     set_ack_i,
   output logic     ack_o,
   output wb_data_t dat_o
);

   slave_idx_t slave_idx;
   logic       req;
   logic       unmapped;
   logic       dflt_ack;      // default slave answer

   assign slave_idx = adr_i[`U1E_AW-1 -: `U1E_DEC_W];
   assign req       = cyc_i & stb_i;
   assign unmapped  = (slave_idx != `U1E_SLV_MISC) && (slave_idx != `U1E_SLV_SETTINGS);

   assign misc_stb_o = req & (slave_idx == `U1E_SLV_MISC);
   assign set_stb_o  = req & (slave_idx == `U1E_SLV_SETTINGS);

   // nothing lives here, so answer once and let the host move on
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         dflt_ack <= 1'b0;
      else
         dflt_ack <= req & unmapped & ~dflt_ack;
   end

   always_comb
   begin
      ack_o = 1'b0;
      dat_o = '0;
      case (slave_idx)
         `U1E_SLV_MISC:
         begin
            ack_o = misc_ack_i;
            dat_o = misc_dat_i;
         end
         `U1E_SLV_SETTINGS:
            ack_o = set_ack_i;      // write only, reads as 0
         default:
            ack_o = dflt_ack;
      endcase
   end

endmodule

//--- hw/core_ctrl_regs.sv
// misc control and status registers (slave 0)
// plus the FIFO-clear setting register on the settings bus
`timescale 1ns/1ps
`include "u1e_config.svh"

module core_ctrl_regs
   import u1e_bus_pkg::*;
   import u1e_settings_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic       stb_i,
   input  logic       we_i,
   input  wb_addr_t   adr_i,
   input  wb_data_t   dat_i,
   output wb_data_t   dat_o,
   output logic       ack_o,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       cgen_st_status_i,
   input  logic       cgen_st_ld_i,
   input  logic       cgen_st_refmon_i,
   input  wb_data_t   rx_frame_len_i,
   output logic [3:0] led_o,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o,
   output wb_data_t   tx_frame_len_o,
   output logic       tx_enable_o,
   output logic       rx_enable_o,
   output logic [7:0] rate_o,
   output logic       clear_tx_o,
   output logic       clear_rx_o
);

   wb_data_t   reg_leds;
   wb_data_t   reg_cgen_ctrl;
   wb_data_t   reg_test;
   wb_data_t   reg_tx_framelen;
   wb_data_t   reg_xfer_rate;
   logic [1:0] clear_bits;    // {tx, rx}
   logic       clear_hit;     // clear setting seen last cycle
   logic       clear_wr;
   logic [6:0] offs;

   assign offs  = adr_i[6:0];
   assign ack_o = stb_i;      // always ready

   //////////////////////////////////////////////////////////////////////
   // host writes
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds        <= '0;
         reg_cgen_ctrl   <= 16'd3;   // sync_b and ref_sel high
         reg_test        <= '0;
         reg_tx_framelen <= '0;
         reg_xfer_rate   <= '0;
      end
      else if (stb_i & we_i)
      begin
         case (offs)
            `REG_LEDS:        reg_leds        <= dat_i;
            `REG_CGEN_CTRL:   reg_cgen_ctrl   <= dat_i;
            `REG_TEST:        reg_test        <= dat_i;
            `REG_TX_FRAMELEN: reg_tx_framelen <= dat_i;
            `REG_XFER_RATE:   reg_xfer_rate   <= dat_i;
            default:          ;                // read-only or hole
         endcase
      end
   end

   always_comb
   begin
      case (offs)
         `REG_LEDS:        dat_o = reg_leds;
         `REG_SWITCHES:    dat_o = '0;
         `REG_CGEN_CTRL:   dat_o = reg_cgen_ctrl;
         `REG_CGEN_ST:     dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         `REG_TEST:        dat_o = reg_test;
         `REG_RX_FRAMELEN: dat_o = rx_frame_len_i;
         `REG_TX_FRAMELEN: dat_o = reg_tx_framelen;
         `REG_XFER_RATE:   dat_o = reg_xfer_rate;
         `REG_COMPAT:      dat_o = {`U1E_WHOAMI, `U1E_COMPAT_NUM};
         default:          dat_o = `U1E_READ_DEFAULT;
      endcase
   end

   assign led_o          = reg_leds[3:0];
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];
   assign tx_frame_len_o = reg_tx_framelen;
   assign tx_enable_o    = reg_xfer_rate[15];
   assign rx_enable_o    = reg_xfer_rate[14];
   assign rate_o         = reg_xfer_rate[7:0];

   //////////////////////////////////////////////////////////////////////
   // FIFO clear, one pulse per settings write
   assign clear_wr = set_stb_i & (set_addr_i == `SR_CLEAR_FIFO);

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         clear_bits <= 2'b00;
         clear_hit  <= 1'b0;
      end
      else
      begin
         clear_hit <= clear_wr;
         if (clear_wr)
            clear_bits <= set_data_i[0][1:0];
      end
   end

   assign clear_tx_o = clear_bits[1] & clear_hit;
   assign clear_rx_o = clear_bits[0] & clear_hit;

endmodule

//--- hw/settings_bridge_16le.sv
// 16-bit bus to 32-bit settings bus bridge (slave 5)
// low half first, the high half fires the strobe
`timescale 1ns/1ps
`include "u1e_config.svh"

module settings_bridge_16le
   import u1e_bus_pkg::*;
   import u1e_settings_pkg::*;
(
   input  logic      wb_clk,
   input  logic      wb_rst,
   input  logic      stb_i,
   input  logic      we_i,
   input  wb_addr_t  adr_i,
   input  wb_data_t  dat_i,
   output logic      ack_o,
   output logic      set_stb_o,
   output set_addr_t set_addr_o,
   output set_data_t set_data_o
);

   wb_data_t low_word;        // last low half written
   logic     wr_low;
   logic     wr_high;

   assign ack_o   = stb_i;
   assign wr_low  = stb_i & we_i & ~adr_i[1];
   assign wr_high = stb_i & we_i &  adr_i[1];

   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
         low_word <= dat_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_high;   // one cycle only
   end

   // 32 settings of 4 bytes each
   always_ff @(posedge wb_clk)
   begin
      if (wr_high)
      begin
         set_addr_o <= set_addr_t'(adr_i[6:2]);
         set_data_o <= {dat_i, low_word};
      end
   end

endmodule

//--- hw/vita_time64.sv
// 64-bit VITA time, seconds and ticks
// PPS sync and edge detect, immediate or PPS-aligned load
`timescale 1ns/1ps
`include "u1e_config.svh"

module vita_time64
   import u1e_settings_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output logic       pps_int_o
);

   logic        pps_s1;
   logic        pps_s2;
   logic        pps_s3;       // previous synced level
   logic        pps_edge;
   vita_secs_t  secs;
   vita_secs_t  pend_secs;
   vita_ticks_t ticks;
   vita_ticks_t pend_ticks;
   logic        mode_pps;     // 1 = load on next PPS
   logic        armed;
   logic        wr_secs;
   logic        wr_ticks;
   logic        wr_mode;
   logic        last_tick;

   assign wr_secs   = set_stb_i & (set_addr_i == `SR_TIME64);
   assign wr_ticks  = set_stb_i & (set_addr_i == (`SR_TIME64 + 8'd1));
   assign wr_mode   = set_stb_i & (set_addr_i == (`SR_TIME64 + 8'd2));
   assign last_tick = (ticks == (`U1E_TICKS_PER_SEC - 32'd1));
   assign pps_edge  = pps_s2 & ~pps_s3;

   assign vita_time_o = {secs, ticks};

   //////////////////////////////////////////////////////////////////////
   // pps input, two flops then rising edge
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_s1    <= 1'b0;
         pps_s2    <= 1'b0;
         pps_s3    <= 1'b0;
         pps_int_o <= 1'b0;
      end
      else
      begin
         pps_s1    <= pps_i;
         pps_s2    <= pps_s1;
         pps_s3    <= pps_s2;
         pps_int_o <= pps_edge;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // pending time and load control
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pend_secs  <= '0;
         pend_ticks <= '0;
         mode_pps   <= 1'b0;
         armed      <= 1'b0;
      end
      else
      begin
         if (wr_secs)
            pend_secs <= set_data_i;
         if (wr_ticks)
            pend_ticks <= set_data_i;
         if (wr_mode)
            mode_pps <= set_data_i[0][0];
         if (wr_ticks & mode_pps)
            armed <= 1'b1;        // wait for the edge
         else if (armed & pps_edge)
            armed <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         secs  <= '0;
         ticks <= '0;
      end
      else if (wr_ticks & ~mode_pps)
      begin
         secs  <= pend_secs;      // immediate load
         ticks <= set_data_i;
      end
      else if (armed & pps_edge)
      begin
         secs  <= pend_secs;
         ticks <= pend_ticks;
      end
      else if (last_tick)
      begin
         secs  <= secs + 32'd1;
         ticks <= '0;
      end
      else
         ticks <= ticks + 32'd1;
   end

endmodule

//--- hw/u1e_core.sv
// control plane top, bus decode plus misc, settings bridge and timer
`timescale 1ns/1ps
`include "u1e_config.svh"

module u1e_core
   import u1e_bus_pkg::*;
   import u1e_settings_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   // host register bus
   input  logic       cyc_i,
   input  logic       stb_i,
   input  logic       we_i,
   input  wb_addr_t   adr_i,
   input  wb_sel_t    sel_i,     // full-word accesses only
   input  wb_data_t   dat_i,
   output wb_data_t   dat_o,
   output logic       ack_o,
   // board status
   input  logic       cgen_st_status_i,
   input  logic       cgen_st_ld_i,
   input  logic       cgen_st_refmon_i,
   input  wb_data_t   rx_frame_len_i,
   input  logic       pps_i,
   // controls
   output logic [3:0] led_o,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o,
   output wb_data_t   tx_frame_len_o,
   output logic       tx_enable_o,
   output logic       rx_enable_o,
   output logic [7:0] rate_o,
   output logic       clear_tx_o,
   output logic       clear_rx_o,
   output vita_time_t vita_time_o,
   output logic       pps_int_o
);

   logic      misc_stb;
   logic      misc_ack;
   wb_data_t  misc_dat;
   logic      bridge_stb;
   logic      bridge_ack;
   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;

   wb_slave_decode u_decode
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .cyc_i(cyc_i), .stb_i(stb_i), .adr_i(adr_i),
      .misc_stb_o(misc_stb), .set_stb_o(bridge_stb),
      .misc_ack_i(misc_ack), .misc_dat_i(misc_dat), .set_ack_i(bridge_ack),
      .ack_o(ack_o), .dat_o(dat_o));

   // slave 0
   core_ctrl_regs u_ctrl
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .stb_i(misc_stb), .we_i(we_i), .adr_i(adr_i),
      .dat_i(dat_i), .dat_o(misc_dat), .ack_o(misc_ack),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .rx_frame_len_i(rx_frame_len_i),
      .led_o(led_o), .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .tx_frame_len_o(tx_frame_len_o), .tx_enable_o(tx_enable_o),
      .rx_enable_o(rx_enable_o), .rate_o(rate_o),
      .clear_tx_o(clear_tx_o), .clear_rx_o(clear_rx_o));

   // slave 5
   settings_bridge_16le u_bridge
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .stb_i(bridge_stb), .we_i(we_i), .adr_i(adr_i),
      .dat_i(dat_i), .ack_o(bridge_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   vita_time64 u_time
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time_o), .pps_int_o(pps_int_o));

endmodule

//--- tb/tb_u1e_core.sv
// testbench for the u1e control plane top
// bus tasks, LFSR, watchdog and directed tests
`timescale 1ns/1ps
`include "u1e_config.svh"

module tb_u1e_core;

   localparam int CLK_PERIOD  = 10;
   localparam int ACK_LIMIT   = 20;
   localparam int TEST_CYCLES = 30 + 40 + 30 + 40 + 40 + 20;   // per test in run order
   localparam logic [10:0] UNMAPPED_ADDR = {4'd9, 7'd0};

   logic        wb_clk = 1'b0;
   logic        wb_rst;
   logic        cyc_i;
   logic        stb_i;
   logic        we_i;
   logic [10:0] adr_i;
   logic [1:0]  sel_i;
   logic [15:0] dat_i;
   logic [15:0] dat_o;
   logic        ack_o;
   logic        cgen_st_status_i;
   logic        cgen_st_ld_i;
   logic        cgen_st_refmon_i;
   logic [15:0] rx_frame_len_i;
   logic        pps_i;
   logic [3:0]  led_o;
   logic        cgen_sync_b_o;
   logic        cgen_ref_sel_o;
   logic [15:0] tx_frame_len_o;
   logic        tx_enable_o;
   logic        rx_enable_o;
   logic [7:0]  rate_o;
   logic        clear_tx_o;
   logic        clear_rx_o;
   logic [63:0] vita_time_o;   // {secs, ticks}
   logic        pps_int_o;

   int          err_count = 0;
   int          fail_count = 0;
   logic [15:0] lfsr_q = 16'd66;

   u1e_core uut (.*);

   always #(CLK_PERIOD / 2) wb_clk = ~wb_clk;

   //////////////////////////////////////////////////////////////////////
   // helpers

   // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
   function automatic logic [15:0] lfsr_bits(input int n);
      logic [15:0] v;
      logic        fb;
      int          i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         v      = {v[14:0], fb};
      end
      return v;
   endfunction

   function automatic logic [10:0] misc_addr(input logic [6:0] offs);
      return {`U1E_SLV_MISC, offs};
   endfunction

   // setting index in bits 6..2 and bit 1 for the high half
   function automatic logic [10:0] setting_addr(input logic [4:0] idx, input logic high);
      return {`U1E_SLV_SETTINGS, idx, high, 1'b0};
   endfunction

   // one clock of the seconds/ticks counter
   function automatic logic [63:0] next_time(input logic [63:0] t);
      if (t[31:0] == `U1E_TICKS_PER_SEC - 32'd1)
         return {t[63:32] + 32'd1, 32'd0};
      return {t[63:32], t[31:0] + 32'd1};
   endfunction

   task automatic report_mismatch(input string msg);
      $display("ERR %0t: %s", $time, msg);
      err_count++;
   endtask

   task automatic bus_cycle(input logic wr, input logic [10:0] addr,
                            input logic [15:0] wdata, output logic [15:0] rdata);
      int waited;
      waited = 0;
      @(posedge wb_clk);
      cyc_i <= 1'b1;
      stb_i <= 1'b1;
      we_i  <= wr;
      adr_i <= addr;
      dat_i <= wdata;
      @(negedge wb_clk);
      while (!ack_o && waited < ACK_LIMIT)
      begin
         @(negedge wb_clk);
         waited++;
      end
      if (!ack_o)
      begin
         $display("bus timeout: address %h gave no ack within %0d cycles", addr, ACK_LIMIT);
         fail_count++;
      end
      rdata = dat_o;
      @(posedge wb_clk);          // write lands on this edge
      cyc_i <= 1'b0;
      stb_i <= 1'b0;
      we_i  <= 1'b0;
   endtask

   task automatic bus_write(input logic [10:0] addr, input logic [15:0] data);
      logic [15:0] ignored;
      bus_cycle(1'b1, addr, data, ignored);
   endtask

   task automatic bus_read(input logic [10:0] addr, output logic [15:0] data);
      bus_cycle(1'b0, addr, 16'd0, data);
   endtask

   task automatic setting_write(input logic [4:0] idx, input logic [31:0] value);
      bus_write(setting_addr(idx, 1'b0), value[15:0]);
      bus_write(setting_addr(idx, 1'b1), value[31:16]);
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests

   task automatic reset_and_identity();
      logic [15:0] rd;
      @(negedge wb_clk);
      if (cgen_sync_b_o !== 1'b1 || cgen_ref_sel_o !== 1'b1)
         report_mismatch("clock-gen control outputs not 1 after reset");
      if (led_o !== 4'd0)
         report_mismatch($sformatf("led_o %h after reset", led_o));
      if (clear_tx_o !== 1'b0 || clear_rx_o !== 1'b0)
         report_mismatch("clear outputs active after reset");
      bus_read(misc_addr(`REG_COMPAT), rd);
      if (rd !== 16'h0002)
         report_mismatch($sformatf("compat read %h expected 0002", rd));
      bus_read(misc_addr(`REG_CGEN_CTRL), rd);
      if (rd !== 16'd3)
         report_mismatch($sformatf("cgen_ctrl read %h expected 0003", rd));
      bus_read(misc_addr(7'd18), rd);
      if (rd !== 16'hBEEF)
         report_mismatch($sformatf("offset 18 read %h expected beef", rd));
      bus_read(misc_addr(`REG_SWITCHES), rd);
      if (rd !== 16'd0)
         report_mismatch($sformatf("switches read %h expected 0000", rd));
   endtask

   task automatic reg_write_read();
      logic [6:0]  offs [4];
      logic [15:0] vals [4];
      logic [15:0] rd;
      logic [15:0] st_v;
      logic [15:0] rxlen_v;
      int          i;
      offs = '{`REG_LEDS, `REG_TEST, `REG_TX_FRAMELEN, `REG_XFER_RATE};
      for (i = 0; i < 4; i++)
      begin
         vals[i] = lfsr_bits(16);
         bus_write(misc_addr(offs[i]), vals[i]);
      end
      for (i = 0; i < 4; i++)
      begin
         bus_read(misc_addr(offs[i]), rd);
         if (rd !== vals[i])
            report_mismatch($sformatf("offset %0d read %h expected %h", offs[i], rd, vals[i]));
      end
      @(negedge wb_clk);
      if (led_o !== vals[0][3:0])
         report_mismatch($sformatf("led_o %h expected %h", led_o, vals[0][3:0]));
      if (tx_frame_len_o !== vals[2])
         report_mismatch($sformatf("tx_frame_len_o %h expected %h", tx_frame_len_o, vals[2]));
      if ({tx_enable_o, rx_enable_o} !== vals[3][15:14])
         report_mismatch("tx/rx enable do not follow xfer rate bits 15..14");
      if (rate_o !== vals[3][7:0])
         report_mismatch($sformatf("rate_o %h expected %h", rate_o, vals[3][7:0]));
      st_v    = lfsr_bits(3);
      rxlen_v = lfsr_bits(16);
      @(posedge wb_clk);
      cgen_st_status_i <= st_v[2];
      cgen_st_ld_i     <= st_v[1];
      cgen_st_refmon_i <= st_v[0];
      rx_frame_len_i   <= rxlen_v;
      bus_read(misc_addr(`REG_CGEN_ST), rd);
      if (rd !== {13'd0, st_v[2:0]})
         report_mismatch($sformatf("cgen_st read %h expected %h", rd, {13'd0, st_v[2:0]}));
      bus_read(misc_addr(`REG_RX_FRAMELEN), rd);
      if (rd !== rxlen_v)
         report_mismatch($sformatf("rx_framelen read %h expected %h", rd, rxlen_v));
   endtask

   // cycle 2 after the high-half write is the only clear cycle
   task automatic watch_clear(input logic exp_tx, input logic exp_rx);
      int c;
      for (c = 1; c <= 4; c++)
      begin
         @(negedge wb_clk);
         if (clear_tx_o !== (exp_tx & (c == 2)))
            report_mismatch($sformatf("clear_tx_o %b in cycle %0d", clear_tx_o, c));
         if (clear_rx_o !== (exp_rx & (c == 2)))
            report_mismatch($sformatf("clear_rx_o %b in cycle %0d", clear_rx_o, c));
      end
   endtask

   task automatic fifo_clear();
      setting_write(5'(`SR_CLEAR_FIFO), 32'd2);
      watch_clear(1'b1, 1'b0);
      setting_write(5'(`SR_CLEAR_FIFO), 32'd1);
      watch_clear(1'b0, 1'b1);
   endtask

   task automatic immediate_time_load();
      logic [63:0] expect_t;
      int          c;
      setting_write(5'(`SR_TIME64 + 8'd2), 32'd0);
      setting_write(5'(`SR_TIME64), 32'd7);
      setting_write(5'(`SR_TIME64 + 8'd1), 32'd95);
      expect_t = {32'd7, 32'd95};
      @(negedge wb_clk);            // strobe on the settings bus
      for (c = 2; c <= 10; c++)
      begin
         @(negedge wb_clk);
         if (vita_time_o !== expect_t)
            report_mismatch($sformatf("vita time %h expected %h", vita_time_o, expect_t));
         expect_t = next_time(expect_t);
      end
      if (vita_time_o[63:32] !== 32'd8)
         report_mismatch("seconds did not wrap to 8");
   endtask

   task automatic pps_time_load();
      logic [63:0] prev;
      int          c;
      setting_write(5'(`SR_TIME64 + 8'd2), 32'd1);
      setting_write(5'(`SR_TIME64), 32'd40);
      setting_write(5'(`SR_TIME64 + 8'd1), 32'd0);
      @(negedge wb_clk);
      prev = vita_time_o;
      for (c = 0; c < 4; c++)
      begin
         @(negedge wb_clk);
         if (vita_time_o !== next_time(prev))
            report_mismatch($sformatf("armed time %h expected %h", vita_time_o, next_time(prev)));
         prev = vita_time_o;
      end
      if (prev[63:32] == 32'd40)
         report_mismatch("seconds loaded before pps");
      @(posedge wb_clk);
      pps_i <= 1'b1;
      c = 0;
      @(negedge wb_clk);
      while (!pps_int_o && c < 10)
      begin
         @(negedge wb_clk);
         c++;
      end
      if (!pps_int_o)
      begin
         $display("pps_int_o never pulsed after pps_i rose");
         fail_count++;
      end
      else
      begin
         if (c > 3)
            report_mismatch($sformatf("pps_int_o came %0d cycles after pps_i", c));
         if (vita_time_o !== {32'd40, 32'd0})
            report_mismatch($sformatf("time at pps %h expected 40 s, 0 ticks", vita_time_o));
         @(negedge wb_clk);
         if (pps_int_o !== 1'b0)
            report_mismatch("pps_int_o longer than one cycle");
         if (vita_time_o !== {32'd40, 32'd1})
            report_mismatch($sformatf("time after pps %h expected 40 s, 1 tick", vita_time_o));
      end
      @(posedge wb_clk);
      pps_i <= 1'b0;
   endtask

   // the unmapped write uses offset 0, the same offset as the LED register
   task automatic unmapped_slave();
      logic [15:0] rd;
      bus_write(misc_addr(`REG_LEDS), 16'h0003);
      bus_write(UNMAPPED_ADDR, 16'h5A5A);
      bus_read(UNMAPPED_ADDR, rd);
      if (rd !== 16'd0)
         report_mismatch($sformatf("unmapped read %h expected 0000", rd));
      bus_read(misc_addr(`REG_LEDS), rd);
      if (rd !== 16'h0003)
         report_mismatch($sformatf("leds read %h after unmapped write expected 0003", rd));
      bus_read(misc_addr(`REG_COMPAT), rd);
      if (rd !== 16'h0002)
         report_mismatch($sformatf("compat read %h after unmapped access", rd));
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence and watchdog
   initial
   begin
      wb_rst           <= 1'b1;
      cyc_i            <= 1'b0;
      stb_i            <= 1'b0;
      we_i             <= 1'b0;
      adr_i            <= '0;
      sel_i            <= 2'b11;
      dat_i            <= '0;
      cgen_st_status_i <= 1'b0;
      cgen_st_ld_i     <= 1'b0;
      cgen_st_refmon_i <= 1'b0;
      rx_frame_len_i   <= '0;
      pps_i            <= 1'b0;
      repeat (5) @(posedge wb_clk);
      wb_rst <= 1'b0;
      reset_and_identity();
      reg_write_read();
      fifo_clear();
      immediate_time_load();
      pps_time_load();
      unmapped_slave();
      repeat (2) @(posedge wb_clk);
      $display("value errors: %0d, other failures: %0d", err_count, fail_count);
      if (err_count == 0 && fail_count == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   initial
   begin
      #((TEST_CYCLES + 10 * ACK_LIMIT) * CLK_PERIOD);
      $display("watchdog: run did not finish in %0d cycles", TEST_CYCLES + 10 * ACK_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- list.f
+incdir+hw
hw/u1e_bus_pkg.sv
hw/u1e_settings_pkg.sv
hw/wb_slave_decode.sv
hw/core_ctrl_regs.sv
hw/settings_bridge_16le.sv
hw/vita_time64.sv
hw/u1e_core.sv
tb/tb_u1e_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the u1e control plane testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module tb_u1e_core \
   -Mdir obj_dir -o sim_u1e \
   && ./obj_dir/sim_u1e > "$LOG" 2>&1 \
   || { echo "build or simulation error"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "^TESTBENCH PASSED$" "$LOG" && echo "run.sh: pass" \
   || { echo "run.sh: fail, see $LOG"; exit 1; }
